// ==== hdl/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word; // data or instruction word, also a byte address
	typedef logic [2:0] lc3b_reg; // register file index
	typedef logic [2:0] lc3b_nzp; // branch condition mask
	typedef logic [8:0] lc3b_offset9; // PC-relative word offset of BR

	// opcode field, bits [15:12] of every instruction
	typedef enum logic [3:0]
	{
		op_br = 4'b0000, // conditional branch, nzp = 000 never taken
		op_add = 4'b0001,
		op_ldb = 4'b0010, // byte load
		op_stb = 4'b0011, // byte store
		op_jsr = 4'b0100, // subroutine call, JSR and JSRR
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_rti = 4'b1000,
		op_not = 4'b1001,
		op_ldi = 4'b1010, // indirect load, two memory trips
		op_sti = 4'b1011, // indirect store
		op_jmp = 4'b1100, // also RET when base is R7
		op_shf = 4'b1101,
		op_lea = 4'b1110,
		op_trap = 4'b1111 // system call through the trap vector table
	} lc3b_opcode;

	// BR layout
	typedef struct packed
	{
		lc3b_opcode opcode;
		lc3b_nzp nzp; // n, z, p from msb down
		lc3b_offset9 offset9;
	} lc3b_br_fmt;

	// register layout shared by ALU, load/store and JMP/JSRR
	typedef struct packed
	{
		lc3b_opcode opcode;
		lc3b_reg dest; // DR or SR depending on opcode
		lc3b_reg base; // SR1 or BaseR
		logic [5:0] rest; // imm, offset6 or SR2 with mode bits
	} lc3b_reg_fmt;

	// one fetched word, two decodings of the same bits
	typedef union packed
	{
		lc3b_br_fmt br;
		lc3b_reg_fmt rg;
	} lc3b_instr;

endpackage : lc3b_types

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	// first fetch address out of reset
	localparam lc3b_types::lc3b_word reset_pc = 16'h0000;

	localparam lc3b_types::lc3b_word pc_step = 16'd2; // byte addressed, 16-bit instructions

endpackage : fetch_pkg

`default_nettype wire

// ==== hdl/fetch_stall_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stall_logic
(
	input logic clk, // sampling clock for the checks below
	input logic rst_n,

	input logic dep_stall, // decode waits on a register dependency
	input logic decode_br_stall, // control instruction sitting in decode
	input logic execute_br_stall, // control instruction sitting in execute
	input logic execute_indirect_stall, // execute splits LDI/STI into two passes
	input logic mem_stall, // data cache busy
	input logic mem_br_stall, // control instruction sitting in memory

	input logic icache_read,
	input logic icache_resp,

	input logic leapfrog_load, // load in memory may be passed by younger work
	input logic leapfrog_stall, // memory holds something that cannot be passed
	input logic lost_leapfrog, // a passed load must be replayed

	output logic valid,
	output logic load_de,
	output logic icache_stall_int
);

	logic br_bubble; // control transfer unresolved somewhere downstream
	logic mem_hold; // memory stall that no leapfrog gets around
	logic freeze; // fetch and decode both hold still

	assign icache_stall_int = icache_read & ~icache_resp; // read out, data not back yet

	assign br_bubble = decode_br_stall
		| execute_br_stall
		| mem_br_stall;

	assign mem_hold = mem_stall & ~leapfrog_load;

	assign freeze = mem_hold
		| leapfrog_stall
		| execute_indirect_stall // EX inserts its own bubble meanwhile
		| dep_stall
		| icache_stall_int
		| lost_leapfrog;

	// weakest request first, a later match overrides an earlier one
	always_comb
	begin
		load_de = 1'b1; // default keeps the pipe moving
		valid = 1'b1;

		if (br_bubble)
		begin
			valid = 1'b0; // decode sees a bubble while the PC still steps
		end

		if (freeze)
		begin
			load_de = 1'b0; // PC and latch hold
			valid = 1'b0;
		end
	end

	// the cache answers only a read that is still outstanding
	a_resp_needs_read : assert property (
		@(posedge clk) disable iff (!rst_n)
		icache_resp |-> icache_read
	) else $error("icache response without an outstanding read");

endmodule : fetch_stall_logic

`default_nettype wire

// ==== hdl/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit
(
	input logic clk,
	input logic rst_n,
	input logic load_de, // fetch accepted a word this cycle
	input logic mem_br_taken, // redirect resolved in memory
	input lc3b_types::lc3b_word mem_br_target,
	output lc3b_types::lc3b_word pc
);

	import lc3b_types::*;
	import fetch_pkg::*;

	lc3b_word pc_next;

	always_comb
	begin
		if (mem_br_taken)
		begin
			pc_next = mem_br_target; // taken branch, jump, call or trap
		end
		else
		begin
			pc_next = pc + pc_step; // next sequential instruction
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc <= reset_pc;
		end
		else if (load_de)
		begin
			pc <= pc_next; // frozen cycles keep the address the cache is working on
		end
	end

	// targets come from the memory stage and must stay word aligned
	a_pc_aligned : assert property (
		@(posedge clk) disable iff (!rst_n)
		pc[0] == 1'b0
	) else $error("odd fetch address %h", pc);

endmodule : pc_unit

`default_nettype wire

// ==== hdl/icache_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_port
(
	input logic clk,
	input logic rst_n,
	input lc3b_types::lc3b_word pc,
	input logic load_de, // word consumed by the latch
	input logic icache_resp,
	input lc3b_types::lc3b_word icache_rdata,
	output logic icache_read,
	output lc3b_types::lc3b_word icache_address,
	output lc3b_types::lc3b_word instr, // word handed to the latch
	output logic ctrl_flow // predecoded control transfer
);

	import lc3b_types::*;

	logic req; // read outstanding toward the cache
	logic held; // returned word parked during a freeze
	lc3b_word held_word;
	lc3b_instr word_view; // same bits as instr, decoded two ways

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			req <= 1'b0;
			held <= 1'b0;
		end
		else if (load_de)
		begin
			req <= 1'b1; // also the first request out of reset
			held <= 1'b0;
		end
		else if (req && icache_resp)
		begin
			req <= 1'b0; // data back but downstream frozen
			held <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req && icache_resp && !load_de)
		begin
			held_word <= icache_rdata; // keep it until the freeze lifts
		end
	end

	assign icache_read = req;
	assign icache_address = pc; // pc moves only on load_de, so it holds during a wait
	assign instr = held ? held_word : icache_rdata;
	assign word_view = instr;

	// JMP, JSR, TRAP always redirect, BR only if some condition bit is set
	always_comb
	begin
		case (word_view.rg.opcode)
			op_jmp, op_jsr, op_trap: ctrl_flow = 1'b1;
			op_br: ctrl_flow = |word_view.br.nzp; // nzp 000 is a nop
			default: ctrl_flow = 1'b0;
		endcase
	end

	// relies on the stall logic freezing the PC until the response
	a_addr_stable : assert property (
		@(posedge clk) disable iff (!rst_n)
		(icache_read && !icache_resp) |=> $stable(icache_address)
	) else $error("icache address moved during a wait");

endmodule : icache_port

`default_nettype wire

// ==== hdl/if_de_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module if_de_latch
(
	input logic clk,
	input logic rst_n,
	input logic load_de,
	input logic valid, // low turns the captured slot into a bubble
	input logic ctrl_flow,
	input lc3b_types::lc3b_word pc,
	input lc3b_types::lc3b_word instr,
	output logic de_valid,
	output logic de_ctrl_flow,
	output lc3b_types::lc3b_word de_pc,
	output lc3b_types::lc3b_word de_instr
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			de_valid <= 1'b0; // decode starts empty
			de_ctrl_flow <= 1'b0;
			de_pc <= '0;
			de_instr <= '0;
		end
		else if (load_de)
		begin
			de_valid <= valid;
			de_ctrl_flow <= ctrl_flow & valid; // a bubble never flags a branch
			de_pc <= pc;
			de_instr <= instr;
		end
	end

endmodule : if_de_latch

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
(
	input logic clk,
	input logic rst_n,
	input logic dep_stall,
	input logic decode_br_stall,
	input logic execute_br_stall,
	input logic execute_indirect_stall,
	input logic mem_stall,
	input logic mem_br_stall,
	input logic leapfrog_load,
	input logic leapfrog_stall,
	input logic lost_leapfrog,
	input logic mem_br_taken,
	input lc3b_types::lc3b_word mem_br_target,
	input logic icache_resp,
	input lc3b_types::lc3b_word icache_rdata,
	output logic icache_read,
	output lc3b_types::lc3b_word icache_address,
	output logic de_valid,
	output logic de_ctrl_flow,
	output lc3b_types::lc3b_word de_pc,
	output lc3b_types::lc3b_word de_instr
);

	import lc3b_types::*;

	lc3b_word pc; // current fetch address
	lc3b_word instr;
	logic ctrl_flow;
	logic load_de; // advance PC and latch
	logic valid;

	pc_unit pc_unit_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.load_de(load_de),
		.mem_br_taken(mem_br_taken),
		.mem_br_target(mem_br_target),
		.pc(pc)
	);

	icache_port icache_port_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.pc(pc),
		.load_de(load_de),
		.icache_resp(icache_resp),
		.icache_rdata(icache_rdata),
		.icache_read(icache_read),
		.icache_address(icache_address),
		.instr(instr),
		.ctrl_flow(ctrl_flow)
	);

	fetch_stall_logic fetch_stall_logic_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.dep_stall(dep_stall),
		.decode_br_stall(decode_br_stall),
		.execute_br_stall(execute_br_stall),
		.execute_indirect_stall(execute_indirect_stall),
		.mem_stall(mem_stall),
		.mem_br_stall(mem_br_stall),
		.icache_read(icache_read),
		.icache_resp(icache_resp),
		.leapfrog_load(leapfrog_load),
		.leapfrog_stall(leapfrog_stall),
		.lost_leapfrog(lost_leapfrog),
		.valid(valid),
		.load_de(load_de),
		.icache_stall_int()
	);

	if_de_latch if_de_latch_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.load_de(load_de),
		.valid(valid),
		.ctrl_flow(ctrl_flow),
		.pc(pc),
		.instr(instr),
		.de_valid(de_valid),
		.de_ctrl_flow(de_ctrl_flow),
		.de_pc(de_pc),
		.de_instr(de_instr)
	);

endmodule : fetch_unit

`default_nettype wire

// ==== testbench/tb_fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;

	import lc3b_types::*;

	localparam int n_cycles = 2000; // cycles run after reset
	localparam int quiet_cycles = 300; // opening stretch without stalls or redirects

	logic clk;
	logic rst_n;
	logic dep_stall, decode_br_stall, execute_br_stall, execute_indirect_stall;
	logic mem_stall, mem_br_stall, leapfrog_load, leapfrog_stall, lost_leapfrog;
	logic mem_br_taken;
	lc3b_word mem_br_target;
	logic icache_resp;
	lc3b_word icache_rdata;
	logic icache_read;
	lc3b_word icache_address;
	logic de_valid, de_ctrl_flow;
	lc3b_word de_pc, de_instr;

	logic [15:0] mem [0:255]; // instruction memory behind the cache
	logic [31:0] seed; // lcg state
	int checks, errors, words_seen;

	logic active; // cache model busy with a read
	logic [1:0] wait_cnt; // cycles left before the response
	logic last_read; // icache_read seen in the previous cycle
	lc3b_word last_addr;

	logic m_req; // model of the outstanding read flag
	lc3b_word m_pc; // model fetch address
	logic exp_valid, exp_cf;
	lc3b_word exp_pc, exp_instr;
	logic redirect_pending; // redirect held until fetch accepts it
	logic seen_valid;

	fetch_unit fetch_unit_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.dep_stall(dep_stall),
		.decode_br_stall(decode_br_stall),
		.execute_br_stall(execute_br_stall),
		.execute_indirect_stall(execute_indirect_stall),
		.mem_stall(mem_stall),
		.mem_br_stall(mem_br_stall),
		.leapfrog_load(leapfrog_load),
		.leapfrog_stall(leapfrog_stall),
		.lost_leapfrog(lost_leapfrog),
		.mem_br_taken(mem_br_taken),
		.mem_br_target(mem_br_target),
		.icache_resp(icache_resp),
		.icache_rdata(icache_rdata),
		.icache_read(icache_read),
		.icache_address(icache_address),
		.de_valid(de_valid),
		.de_ctrl_flow(de_ctrl_flow),
		.de_pc(de_pc),
		.de_instr(de_instr)
	);

	always #50 clk = ~clk; // 100 ns period

	function logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return {16'd0, seed[30:15]}; // upper bits, low ones cycle too fast
	endfunction

	function logic chance(input int unsigned one_in);
		logic [31:0] r;
		r = next_rand();
		return (r % one_in) == 32'd0;
	endfunction

	// JMP, JSR, TRAP always, BR only with some nzp bit set
	function logic is_ctrl_flow(input logic [15:0] w);
		case (w[15:12])
			4'b1100, 4'b0100, 4'b1111: return 1'b1;
			4'b0000: return |w[11:9];
			default: return 1'b0;
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("FAIL %s: expected %h, actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	// one clock edge of the fetch stage, from the inputs held during the last cycle
	task automatic advance_model();
		logic stall_int;
		logic freeze;
		logic bubble;
		stall_int = m_req & ~icache_resp; // read out, nothing back
		freeze = (mem_stall & ~leapfrog_load) | leapfrog_stall | execute_indirect_stall
			| dep_stall | stall_int | lost_leapfrog;
		bubble = decode_br_stall | execute_br_stall | mem_br_stall;
		if (!freeze)
		begin
			exp_valid = ~bubble; // branch stall loads a bubble
			exp_pc = m_pc;
			exp_instr = mem[m_pc[8:1]];
			exp_cf = ~bubble & is_ctrl_flow(mem[m_pc[8:1]]);
			if (mem_br_taken)
			begin
				m_pc = mem_br_target; // redirect wins over the step
				redirect_pending = 1'b0;
			end
			else
			begin
				m_pc = m_pc + 16'd2;
			end
			m_req = 1'b1; // next read starts after an accepted word
		end
		else if (m_req && icache_resp)
		begin
			m_req = 1'b0; // word parked while frozen
		end
	endtask

	task automatic check_outputs();
		compare_value("de_valid", {15'd0, exp_valid}, {15'd0, de_valid});
		compare_value("de_pc", exp_pc, de_pc); // held across freezes
		compare_value("de_instr", exp_instr, de_instr);
		compare_value("de_ctrl_flow", {15'd0, exp_cf}, {15'd0, de_ctrl_flow});
		compare_value("icache_read", {15'd0, m_req}, {15'd0, icache_read});
		if (last_read && !icache_resp)
		begin
			compare_value("icache_address stable", last_addr, icache_address);
		end
		if (de_valid && !seen_valid)
		begin
			compare_value("first de_pc", 16'h0000, de_pc);
			seen_valid = 1'b1;
		end
		if (de_valid)
		begin
			words_seen++;
		end
	endtask

	task automatic drive_inputs(input logic noisy);
		logic [31:0] r;
		if (last_read && icache_resp)
		begin
			active = 1'b0; // transfer finished on the last edge
		end
		if (icache_read && !active)
		begin
			active = 1'b1;
			r = next_rand();
			wait_cnt = r[1:0]; // 0 to 3 extra cycles
		end
		if (active && wait_cnt == 2'd0)
		begin
			icache_resp = 1'b1;
		end
		else
		begin
			icache_resp = 1'b0;
			if (active)
			begin
				wait_cnt = wait_cnt - 2'd1;
			end
		end
		icache_rdata = mem[icache_address[8:1]]; // data bus shows the addressed word
		last_read = icache_read;
		last_addr = icache_address;

		dep_stall = noisy & chance(32);
		decode_br_stall = noisy & chance(16);
		execute_br_stall = noisy & chance(16);
		execute_indirect_stall = noisy & chance(32);
		mem_stall = noisy & chance(8);
		mem_br_stall = noisy & chance(16);
		leapfrog_load = noisy & chance(2); // often paired with mem_stall
		leapfrog_stall = noisy & chance(32);
		lost_leapfrog = noisy & chance(32);
		if (noisy && !redirect_pending && chance(24))
		begin
			redirect_pending = 1'b1;
			r = next_rand();
			mem_br_target = {r[14:0], 1'b0}; // any even address
		end
		mem_br_taken = redirect_pending;
	endtask

	initial
	begin
		logic [31:0] draw; // one lcg draw for the memory fill
		clk = 1'b0;
		rst_n = 1'b0;
		seed = 32'd89;
		{dep_stall, decode_br_stall, execute_br_stall, execute_indirect_stall} = 4'b0;
		{mem_stall, mem_br_stall, leapfrog_load, leapfrog_stall, lost_leapfrog} = 5'b0;
		mem_br_taken = 1'b0;
		mem_br_target = 16'h0000;
		icache_resp = 1'b0;
		icache_rdata = 16'h0000;
		{active, wait_cnt, last_read, last_addr} = '0;
		{m_req, exp_valid, exp_cf, redirect_pending, seen_valid} = 5'b0;
		m_pc = 16'h0000;
		exp_pc = 16'h0000;
		exp_instr = 16'h0000;
		checks = 0;
		errors = 0;
		words_seen = 0;
		for (int i = 0; i < 256; i++)
		begin
			draw = next_rand();
			mem[i[7:0]] = draw[15:0]; // low 16 bits of the draw
			draw = next_rand();
			mem[i[7:0]][15:12] = draw[3:0]; // opcode drawn on its own
		end

		repeat (16) @(posedge clk);
		#1;
		compare_value("reset de_valid", 16'd0, {15'd0, de_valid});
		compare_value("reset icache_read", 16'd0, {15'd0, icache_read});
		rst_n = 1'b1;
		drive_inputs(1'b0);

		for (int cyc = 0; cyc < n_cycles; cyc++)
		begin
			@(posedge clk);
			advance_model();
			#1; // outputs settled, inputs not yet changed
			check_outputs();
			drive_inputs(cyc >= quiet_cycles);
		end

		if (words_seen < 100)
		begin
			errors++;
			$display("ERROR: fetch delivered only %0d valid words", words_seen);
		end
		$display("checks %0d, errors %0d, valid words %0d", checks, errors, words_seen);
		if (errors == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial
	begin
		#((16 + n_cycles + 100) * 100); // reset plus test length plus margin
		$display("ERROR: watchdog expired before the test sequence ended");
		$display("TB FAILED");
		$finish;
	end

endmodule : tb_fetch_unit

`default_nettype wire

// ==== filelist.f ====
hdl/lc3b_types.sv
hdl/fetch_pkg.sv
hdl/fetch_stall_logic.sv
hdl/pc_unit.sv
hdl/icache_port.sv
hdl/if_de_latch.sv
hdl/fetch_unit.sv
testbench/tb_fetch_unit.sv

// ==== Makefile ====
SRCS := $(shell cat filelist.f)

obj_dir/Vtb_fetch_unit: filelist.f $(SRCS)
	verilator --binary --assert -f filelist.f --top-module tb_fetch_unit -o Vtb_fetch_unit

run: obj_dir/Vtb_fetch_unit
	./obj_dir/Vtb_fetch_unit > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
